// File: rtl/link_pkg.sv
`default_nettype none

package link_pkg;

	//////////////////////////////////////////////////////////////////////
	// core word geometry
	//////////////////////////////////////////////////////////////////////

	localparam int code_w = 8; // code part, sent first
	localparam int data_w = 24;
	localparam int word_w = code_w + data_w; // 32 bit core word
	localparam int pad_w = 2; // top code bits, always zero, never routed
	localparam int routed_w = word_w - pad_w; // 30 bits actually cross the link

	//////////////////////////////////////////////////////////////////////
	// flit geometry
	//////////////////////////////////////////////////////////////////////

	localparam int field_w = 10; // flit payload field
	localparam int route_w = 10; // header field is the route
	localparam int flits_per_word = routed_w / field_w; // 3 data flits per word

	// slice positions in the routed part, high slice travels first
	localparam int part0_lsb = (flits_per_word - 1) * field_w; // bits 29:20
	localparam int part1_lsb = (flits_per_word - 2) * field_w; // bits 19:10
	localparam int part2_lsb = 0; // bits 9:0

	localparam int fifo_depth = 8; // link buffer entries

	typedef struct packed {
		logic tail; // set only on the last flit of a packet
		logic [field_w-1:0] field; // route on a header, word slice otherwise
	} flit_t; // 11 bits on the link

endpackage

`default_nettype wire

// File: rtl/flit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// valid/ready circular buffer, stands in for the router queue
module flit_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input wire logic clk,
	input wire logic reset, // sync, active low
	input wire logic wr_valid,
	input wire payload_t wr_data,
	input wire logic rd_ready,
	output logic wr_ready,
	output logic rd_valid,
	output payload_t rd_data
);

	import link_pkg::*;

	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1); // must hold the full value

	payload_t mem [fifo_depth]; // storage, no reset

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count; // occupancy
	logic do_push;
	logic do_pop;

	assign wr_ready = (count != cnt_w'(fifo_depth)); // low only when full
	assign rd_valid = (count != '0);
	assign rd_data = mem[rd_ptr]; // head entry straight from storage
	assign do_push = wr_valid && wr_ready;
	assign do_pop = rd_valid && rd_ready;

	//////////////////////////////////////////////////////////////////////
	// pointers and count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither, occupancy unchanged
			endcase
		end
	end

	// write lands on the edge, visible at the head from the next cycle
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
		count <= cnt_w'(fifo_depth));

	// occupancy tracks the pointer gap, a pop past empty would break it
	a_ptr_count: assert property (@(posedge clk) disable iff (!reset)
		(count % fifo_depth) == ((wr_ptr + fifo_depth - rd_ptr) % fifo_depth));

endmodule

`default_nettype wire

// File: rtl/flit_packetizer.sv
`timescale 1ns/1ns
`default_nettype none

// splits core words into a header flit plus three data flits per word
module flit_packetizer (
	input wire logic clk,
	input wire logic reset, // sync, active low
	input wire logic in_valid,
	input wire logic [link_pkg::word_w-1:0] in_word,
	input wire logic [link_pkg::route_w-1:0] in_route, // used on first word only
	input wire logic in_last, // final word of the packet
	input wire logic flit_ready,
	output logic in_ready,
	output logic flit_valid,
	output link_pkg::flit_t flit
);

	import link_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_header,
		st_data0,
		st_data1,
		st_data2
	} state_t;

	state_t state;

	logic [routed_w-1:0] word_q; // routed part only, pad bits dropped
	logic [route_w-1:0] route_q;
	logic last_q; // current word closes the packet
	logic first_q; // next accepted word opens a packet
	logic take; // word handshake
	logic send; // flit handshake

	assign take = in_valid && in_ready;
	assign send = flit_valid && flit_ready;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_idle;
			first_q <= 1'b1; // first word after reset opens a packet
		end else begin
			case (state)
				st_idle: begin
					if (take) begin
						state <= first_q ? st_header : st_data0; // header once per packet
					end
				end
				st_header: if (send) state <= st_data0;
				st_data0: if (send) state <= st_data1;
				st_data1: if (send) state <= st_data2;
				st_data2: begin
					if (send) begin
						state <= st_idle;
						first_q <= last_q; // a closed packet means the next word opens one
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// word, route and last flag captured on acceptance
	always_ff @(posedge clk) begin
		if (take) begin
			word_q <= in_word[routed_w-1:0];
			last_q <= in_last;
			if (first_q) begin
				route_q <= in_route; // route is only sampled on the packet's first word
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// flit output, pure decode of registers so a stall holds it
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		in_ready = 1'b0;
		flit_valid = 1'b0;
		flit = '0;
		case (state)
			st_idle: in_ready = 1'b1; // only idle between words
			st_header: begin
				flit_valid = 1'b1;
				flit.field = route_q; // tail stays 0 on a header
			end
			st_data0: begin
				flit_valid = 1'b1;
				flit.field = word_q[part0_lsb +: field_w]; // high slice
			end
			st_data1: begin
				flit_valid = 1'b1;
				flit.field = word_q[part1_lsb +: field_w];
			end
			st_data2: begin
				flit_valid = 1'b1;
				flit.field = word_q[part2_lsb +: field_w]; // low slice
				flit.tail = last_q; // marks end of packet
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// source must never hand over a word with the unrouted code bits set
	a_pad_zero: assert property (@(posedge clk) disable iff (!reset)
		in_valid |-> in_word[word_w-1 -: pad_w] == '0);

	// a stalled flit is held for the buffer
	a_flit_hold: assert property (@(posedge clk) disable iff (!reset)
		flit_valid && !flit_ready |=> flit_valid && $stable(flit));

endmodule

`default_nettype wire

// File: rtl/word_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

// reassembles data flits into core words, keeps the header route
module word_deserializer (
	input wire logic clk,
	input wire logic reset, // sync, active low
	input wire logic link_valid,
	input wire link_pkg::flit_t link_flit,
	input wire logic out_ready,
	output logic link_ready,
	output logic out_valid,
	output logic [link_pkg::word_w-1:0] out_word, // top pad bits always zero
	output logic [link_pkg::route_w-1:0] out_route,
	output logic out_last
);

	import link_pkg::*;

	typedef enum logic [2:0] {
		st_header, // waiting for the packet's header flit
		st_part0,
		st_part1,
		st_part2,
		st_hold // full word presented to the core
	} state_t;

	state_t state;

	logic [routed_w-1:0] word_q; // 30 routed bits
	logic [route_w-1:0] route_q;
	logic last_q; // tail bit seen on the third flit
	logic accept; // flit handshake
	logic done; // word handshake

	assign link_ready = (state != st_hold); // one flit per cycle while collecting
	assign out_valid = (state == st_hold);
	assign accept = link_valid && link_ready;
	assign done = out_valid && out_ready;

	assign out_word = {{pad_w{1'b0}}, word_q}; // unrouted code bits put back as zero
	assign out_route = route_q;
	assign out_last = last_q;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_header; // a packet always starts with its header
		end else begin
			case (state)
				st_header: if (accept) state <= st_part0;
				st_part0: if (accept) state <= st_part1;
				st_part1: if (accept) state <= st_part2;
				st_part2: if (accept) state <= st_hold;
				st_hold: begin
					if (done) begin
						// tail decides what the next flit is
						state <= last_q ? st_header : st_part0;
					end
				end
				default: state <= st_header;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			case (state)
				st_header: route_q <= link_flit.field; // header carries only the route
				st_part0: word_q[part0_lsb +: field_w] <= link_flit.field; // high slice first
				st_part1: word_q[part1_lsb +: field_w] <= link_flit.field;
				st_part2: begin
					word_q[part2_lsb +: field_w] <= link_flit.field;
					last_q <= link_flit.tail; // only the third flit's tail counts
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// core side sees a steady word until it takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!reset)
		out_valid && !out_ready |=> out_valid && $stable(out_word)
			&& $stable(out_route) && $stable(out_last));

endmodule

`default_nettype wire

// File: rtl/link_top.sv
`timescale 1ns/1ns
`default_nettype none

// core words in, flits over the buffered link, core words out
module link_top (
	input wire logic clk,
	input wire logic reset, // sync, active low
	input wire logic in_valid,
	input wire logic [link_pkg::word_w-1:0] in_word,
	input wire logic [link_pkg::route_w-1:0] in_route,
	input wire logic in_last,
	input wire logic out_ready,
	output logic in_ready,
	output logic out_valid,
	output logic [link_pkg::word_w-1:0] out_word,
	output logic [link_pkg::route_w-1:0] out_route,
	output logic out_last
);

	import link_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// link wires
	//////////////////////////////////////////////////////////////////////

	logic flit_valid; // producer side
	logic flit_ready;
	flit_t flit;

	logic link_valid; // consumer side
	logic link_ready;
	flit_t link_flit;

	flit_packetizer i_packetizer (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_word(in_word),
		.in_route(in_route),
		.in_last(in_last),
		.flit_ready(flit_ready),
		.in_ready(in_ready),
		.flit_valid(flit_valid),
		.flit(flit)
	);

	// router queue stand-in
	flit_fifo #(
		.payload_t(flit_t)
	) i_fifo (
		.clk(clk),
		.reset(reset),
		.wr_valid(flit_valid),
		.wr_data(flit),
		.rd_ready(link_ready),
		.wr_ready(flit_ready),
		.rd_valid(link_valid),
		.rd_data(link_flit)
	);

	word_deserializer i_deserializer (
		.clk(clk),
		.reset(reset),
		.link_valid(link_valid),
		.link_flit(link_flit),
		.out_ready(out_ready),
		.link_ready(link_ready),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_route(out_route),
		.out_last(out_last)
	);

endmodule

`default_nettype wire

// File: test/tb_link.sv
`timescale 1ns/1ns
`default_nettype none

module tb_link;

	import link_pkg::*;

	localparam int max_words = 64; // room in the stimulus memory
	localparam logic [31:0] lfsr_taps = 32'hb4bc_d35c; // maximal length, right shifting

	logic clk;
	logic reset;
	logic in_valid;
	logic [word_w-1:0] in_word;
	logic [route_w-1:0] in_route;
	logic in_last;
	logic out_ready;
	logic in_ready;
	logic out_valid;
	logic [word_w-1:0] out_word;
	logic [route_w-1:0] out_route;
	logic out_last;

	logic [31:0] stim [3*max_words]; // triples of route, last, word
	logic [31:0] lfsr;
	int n_words; // words found in the data file
	int limit; // timeout in cycles
	int cycles;
	int sent; // words taken by the DUT
	int seen; // words handed out by the DUT
	bit first_of_pkt; // next accepted word opens a packet
	logic [route_w-1:0] pkt_route; // route in force for the current packet

	// expected stream, in order
	logic [word_w-1:0] exp_word [$];
	logic [route_w-1:0] exp_route [$];
	logic exp_last [$];

	// last presented output, for the stall check
	bit held;
	logic [word_w-1:0] held_word;
	logic [route_w-1:0] held_route;
	logic held_last;

	int value_errors;
	int other_errors;
	int timeouts;

	link_top i_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_word(in_word),
		.in_route(in_route),
		.in_last(in_last),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_route(out_route),
		.out_last(out_last)
	);

	always #20 clk = ~clk; // 40 ns period

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsr_taps; // feed back into the tap positions
		end
		return n;
	endfunction

	// one step per bit taken
	function automatic bit random_bit();
		lfsr = lfsr_step(lfsr);
		return lfsr[0];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		value_errors++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus, driven on the rising edge
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			in_valid <= 1'b0;
			out_ready <= 1'b0;
		end else begin
			if (in_valid && in_ready) begin // word taken on this edge
				if (first_of_pkt) begin
					pkt_route = in_route; // later words of the packet keep it
				end
				exp_word.push_back(in_word);
				exp_route.push_back(pkt_route);
				exp_last.push_back(in_last);
				first_of_pkt = in_last; // closed packet, next word opens one
				sent++;
			end
			if (!in_valid || in_ready) begin // free to offer, else hold the word
				if (sent < n_words) begin
					if (random_bit()) begin
						in_route <= stim[3*sent][route_w-1:0];
						in_last <= stim[3*sent+1][0];
						in_word <= stim[3*sent+2];
						in_valid <= 1'b1;
					end else begin
						in_valid <= 1'b0; // idle this cycle
					end
				end else begin
					in_valid <= 1'b0; // stream exhausted
				end
			end
			out_ready <= random_bit(); // random back-pressure
		end
	end

	//////////////////////////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		logic [word_w-1:0] w;
		logic [route_w-1:0] r;
		logic l;
		if (!reset) begin
			held = 1'b0;
		end else begin
			if (held) begin // stalled last cycle, outputs must not move
				assert (out_valid) else begin
					$display("%0t: out_valid dropped while the word was stalled", $time);
					other_errors++;
				end
				assert (out_word == held_word) else report_mismatch("out_word", held_word, out_word);
				assert (out_route == held_route)
					else report_mismatch("out_route", 32'(held_route), 32'(out_route));
				assert (out_last == held_last)
					else report_mismatch("out_last", 32'(held_last), 32'(out_last));
			end
			held = out_valid && !out_ready;
			held_word = out_word;
			held_route = out_route;
			held_last = out_last;
			if (out_valid && out_ready) begin
				assert (exp_word.size() > 0) else begin
					$display("%0t: a word came out while none was expected", $time);
					other_errors++;
				end
				if (exp_word.size() > 0) begin
					w = exp_word.pop_front();
					r = exp_route.pop_front();
					l = exp_last.pop_front();
					assert (out_word == w) else report_mismatch("out_word", w, out_word);
					assert (out_word[word_w-1 -: pad_w] == '0)
						else report_mismatch("out_word pad", 32'd0, out_word);
					assert (out_route == r) else report_mismatch("out_route", 32'(r), 32'(out_route));
					assert (out_last == l) else report_mismatch("out_last", 32'(l), 32'(out_last));
				end
				seen++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// sequence, timeout and result
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset <= 1'b0; // held low for two edges
		in_valid <= 1'b0;
		in_word <= '0;
		in_route <= '0;
		in_last <= 1'b0;
		out_ready <= 1'b0;
		lfsr = 32'h1f2e;
		sent = 0;
		seen = 0;
		first_of_pkt = 1'b1;
		pkt_route = '0;
		held = 1'b0;
		value_errors = 0;
		other_errors = 0;
		timeouts = 0;

		// unused entries keep a marker with the top bits set, never a legal line
		for (int i = 0; i < 3*max_words; i++) begin
			stim[i] = 32'hc000_0000 | 32'(i);
		end
		$readmemh("test/link_testdata.txt", stim);
		n_words = 0;
		while (n_words < max_words && stim[3*n_words][31:30] == 2'b00) begin
			n_words++;
		end
		assert (n_words > 0) else begin
			$display("no words found in the data file");
			other_errors++;
		end
		limit = n_words * 4 * 8 + 200; // four flits per word, generous stall margin

		repeat (2) @(posedge clk);
		reset <= 1'b1;

		cycles = 0;
		while (seen < n_words && cycles < limit) begin
			@(negedge clk); // sample away from the driving edge
			cycles++;
		end

		if (seen < n_words) begin
			$display("timeout after %0d cycles, %0d of %0d words came out", cycles, seen, n_words);
			timeouts++;
		end else begin
			repeat (2) @(negedge clk); // drained, let the link settle
			assert (exp_word.size() == 0) else begin
				$display("%0d expected words never came out", exp_word.size());
				other_errors++;
			end
			assert (sent == n_words) else begin
				$display("only %0d of %0d words were accepted", sent, n_words);
				other_errors++;
			end
			assert (in_ready) else begin
				$display("in_ready is still low after the stream drained");
				other_errors++;
			end
			assert (!out_valid) else begin
				$display("out_valid is high with no word left to send");
				other_errors++;
			end
		end

		$display("errors: %0d value, %0d protocol, %0d timeout", value_errors, other_errors,
			timeouts);
		if (value_errors + other_errors + timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
rtl/link_pkg.sv
rtl/flit_fifo.sv
rtl/flit_packetizer.sv
rtl/word_deserializer.sv
rtl/link_top.sv
test/tb_link.sv

// File: run.sh
#!/bin/sh
# build the link testbench with verilator, run it, then scan the log
rm -f build.log sim.log
verilator --binary --assert --timescale 1ns/1ns -Wno-fatal --top-module tb_link \
	-f project.f -o tb_link > build.log 2>&1 \
	&& ./obj_dir/tb_link > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// File: test/link_testdata.txt
// columns: route (hex, 10 bits), last flag (0 or 1), core word (hex, top two bits zero)
// the route only counts on a packet's first word, later lines carry other routes on purpose
// one word, all-ones route, full-scale word
3ff 1 3fffffff
// three words
001 0 00000000
2aa 0 15555555
155 1 2aaaaaaa
// five words
0f0 0 12345678
000 0 3fffffff
000 0 00000001
000 0 20000000
000 1 0abcdef0
// one word, all zero
000 1 00000000
// two words
3ff 0 3ff003ff
3ff 1 000ffc00
// four words
123 0 1c71c71c
321 0 0e38e38e
123 0 3c3c3c3c
123 1 03030303
// one word
200 1 20080200
// five words
07f 0 00000400
07f 0 00100000
07f 0 3ffffc00
07f 0 000003ff
07f 1 2468ace0
// three words
3fe 0 13579bdf
001 0 0fedcba9
3fe 1 3fffffff
// one word
0aa 1 11111111
// four words
355 0 22222222
355 0 33333333
0cc 0 00c0ffee
355 1 3ffffffe
